// ==== build.f ====
src/z80_pkg.sv
src/reg_file.sv
src/opcode_decoder.sv
src/load_sequencer.sv
src/z80_seq_top.sv
test/tb_memory.sv
test/z80_seq_sva.sv
test/z80_seq_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the Z80 load sequencer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module z80_seq_tb \
    -f build.f \
    -o z80_seq_sim

# the log holds the verdict
./obj_dir/z80_seq_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== src/load_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_sequencer (
    input  wire                           clk,
    input  wire                           reset,
    input  wire  [z80_pkg::data_w-1:0]    mem_data,
    output logic [z80_pkg::data_w-1:0]    opcode,
    input  z80_pkg::decode_t              dec,
    output z80_pkg::reg_sel_e             rd_sel1,
    output z80_pkg::reg_sel_e             rd_sel2,
    input  wire  [z80_pkg::word_w-1:0]    rd_data1,
    input  wire  [z80_pkg::word_w-1:0]    rd_data2,
    output z80_pkg::reg_wr_t              wr,
    output z80_pkg::mem_req_t             mem_req,
    output logic                          done
);
    import z80_pkg::*;

    seq_state_e        state;
    seq_state_e        next_state;
    logic [data_w-1:0] op_q;
    logic [addr_w-1:0] scratch_addr;
    logic [addr_w-1:0] next_scratch_addr;
    logic [word_w-1:0] scratch_data;
    logic [word_w-1:0] next_scratch_data;
    mem_req_t          next_req;
    logic              next_done;
    logic [addr_w-1:0] cur_addr;
    logic [addr_w-1:0] inc_addr;

    function automatic mem_req_t read_req(input logic [addr_w-1:0] a);
        read_req = '{addr: a, read: 1'b1, write: 1'b0, wdata: '0};
    endfunction

    function automatic mem_req_t write_req(input logic [addr_w-1:0] a,
                                           input logic [data_w-1:0] d);
        write_req = '{addr: a, read: 1'b0, write: 1'b1, wdata: d};
    endfunction

    assign cur_addr = mem_req.addr;  // the PC while fetching
    assign inc_addr = cur_addr + addr_w'(1);
    assign opcode   = (state == st_0) ? mem_data : op_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= st_0;
            done    <= 1'b1;
            mem_req <= read_req('0);
        end else begin
            state   <= next_state;
            done    <= next_done;
            mem_req <= next_req;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_0)
            op_q <= mem_data;
        scratch_addr <= next_scratch_addr;
        scratch_data <= next_scratch_data;
    end

    always_comb begin
        next_state        = st_0;
        next_done         = 1'b0;
        next_req          = '{addr: cur_addr, read: 1'b0, write: 1'b0, wdata: '0};
        next_scratch_addr = scratch_addr;
        next_scratch_data = scratch_data;
        rd_sel1           = reg_hl;
        rd_sel2           = reg_a;
        wr                = '{en: 1'b0, dest: reg_a, data: '0};

        case (dec.group)
            grp_ld_r_r: begin
                rd_sel1   = dec.src;
                wr        = '{en: 1'b1, dest: dec.dst, data: word_w'(rd_data1[data_w-1:0])};
                next_req  = read_req(inc_addr);
                next_done = 1'b1;
            end

            grp_ld_r_n:
                case (state)
                    st_0: begin
                        next_req   = read_req(inc_addr);
                        next_state = st_1;
                    end
                    st_1: begin
                        wr        = '{en: 1'b1, dest: dec.dst, data: word_w'(mem_data)};
                        next_req  = read_req(inc_addr);
                        next_done = 1'b1;
                    end
                    default: ;
                endcase

            grp_ld_hl_r:
                case (state)
                    st_0: begin
                        rd_sel1           = reg_hl;
                        rd_sel2           = dec.src;
                        next_scratch_addr = inc_addr;
                        next_req          = write_req(rd_data1, rd_data2[data_w-1:0]);
                        next_state        = st_1;
                    end
                    st_1: begin
                        next_req  = read_req(scratch_addr);
                        next_done = 1'b1;
                    end
                    default: ;
                endcase

            grp_ld_hl_n:
                case (state)
                    st_0: begin
                        next_req   = read_req(inc_addr);
                        next_state = st_1;
                    end
                    st_1: begin
                        rd_sel1           = reg_hl;
                        next_scratch_addr = inc_addr;
                        next_req          = write_req(rd_data1, mem_data);
                        next_state        = st_2;
                    end
                    st_2: begin
                        next_req  = read_req(scratch_addr);
                        next_done = 1'b1;
                    end
                    default: ;
                endcase

            grp_ld_a_bcde:
                case (state)
                    st_0: begin
                        rd_sel1           = dec.pair;  // BC or DE
                        next_scratch_addr = inc_addr;
                        next_req          = read_req(rd_data1);
                        next_state        = st_1;
                    end
                    st_1: begin
                        wr        = '{en: 1'b1, dest: reg_a, data: word_w'(mem_data)};
                        next_req  = read_req(scratch_addr);
                        next_done = 1'b1;
                    end
                    default: ;
                endcase

            grp_ld_bcde_a:
                case (state)
                    st_0: begin
                        rd_sel1           = reg_a;
                        rd_sel2           = dec.pair;
                        next_scratch_addr = inc_addr;
                        next_req          = write_req(rd_data2, rd_data1[data_w-1:0]);
                        next_state        = st_1;
                    end
                    st_1: begin
                        next_req  = read_req(scratch_addr);
                        next_done = 1'b1;
                    end
                    default: ;
                endcase

            grp_ld_a_nn, grp_ld_nn_a:
                case (state)
                    st_0: begin
                        next_req   = read_req(inc_addr);
                        next_state = st_1;
                    end
                    st_1: begin
                        next_scratch_addr = addr_w'(mem_data);  // low byte of nn
                        next_req          = read_req(inc_addr);
                        next_state        = st_2;
                    end
                    st_2: begin
                        rd_sel1           = reg_a;
                        next_scratch_addr = inc_addr;
                        if (dec.group == grp_ld_a_nn)
                            next_req = read_req({mem_data, scratch_addr[data_w-1:0]});
                        else
                            next_req = write_req({mem_data, scratch_addr[data_w-1:0]},
                                                 rd_data1[data_w-1:0]);
                        next_state = st_3;
                    end
                    st_3: begin
                        if (dec.group == grp_ld_a_nn)
                            wr = '{en: 1'b1, dest: reg_a, data: word_w'(mem_data)};
                        next_req  = read_req(scratch_addr);
                        next_done = 1'b1;
                    end
                    default: ;
                endcase

            grp_ld_dd_nn:
                case (state)
                    st_0: begin
                        next_req   = read_req(inc_addr);
                        next_state = st_1;
                    end
                    st_1: begin
                        next_scratch_data = word_w'(mem_data);
                        next_req          = read_req(inc_addr);
                        next_state        = st_2;
                    end
                    st_2: begin
                        wr = '{en: 1'b1, dest: dec.pair,
                               data: {mem_data, scratch_data[data_w-1:0]}};
                        next_req  = read_req(inc_addr);
                        next_done = 1'b1;
                    end
                    default: ;
                endcase

            grp_ld_nn_hl:
                case (state)
                    st_0: begin
                        next_req   = read_req(inc_addr);
                        next_state = st_1;
                    end
                    st_1: begin
                        next_scratch_data = word_w'(mem_data);
                        next_req          = read_req(inc_addr);
                        next_state        = st_2;
                    end
                    st_2: begin
                        // L goes to nn, keep nn+1 for H
                        rd_sel1           = reg_hl;
                        next_scratch_addr = inc_addr;
                        next_scratch_data = {mem_data, scratch_data[data_w-1:0]} + word_w'(1);
                        next_req          = write_req({mem_data, scratch_data[data_w-1:0]},
                                                      rd_data1[data_w-1:0]);
                        next_state        = st_3;
                    end
                    st_3: begin
                        rd_sel1    = reg_hl;
                        next_req   = write_req(scratch_data, rd_data1[word_w-1:data_w]);
                        next_state = st_4;
                    end
                    st_4: begin
                        next_req  = read_req(scratch_addr);
                        next_done = 1'b1;
                    end
                    default: ;
                endcase

            default: begin  // unknown opcode, skip one byte
                next_req  = read_req(inc_addr);
                next_done = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/opcode_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder (
    input  wire  [z80_pkg::data_w-1:0] opcode,
    output z80_pkg::decode_t           dec
);
    import z80_pkg::*;

    always_comb begin
        dec.dst   = reg_sel_e'({1'b0, opcode[5:3]});
        dec.src   = reg_sel_e'({1'b0, opcode[2:0]});
        dec.pair  = reg_sel_e'({2'b10, opcode[5:4]});
        dec.group = grp_nop;

        if (opcode[7:6] == 2'b01) begin
            // 76h is HALT, and r,(HL) is not handled here
            if (opcode == 8'h76) begin
                dec.group = grp_nop;
            end else if (opcode[5:3] == 3'b110) begin
                dec.group = grp_ld_hl_r;
            end else if (opcode[2:0] != 3'b110) begin
                dec.group = grp_ld_r_r;
            end
        end else if (opcode[7:6] == 2'b00) begin
            if (opcode[2:0] == 3'b110) begin
                // 36h is the (HL) slot of LD r,n
                dec.group = (opcode[5:3] == 3'b110) ? grp_ld_hl_n : grp_ld_r_n;
            end else begin
                case (opcode)
                    8'h01, 8'h11, 8'h21, 8'h31: dec.group = grp_ld_dd_nn;
                    8'h02, 8'h12:               dec.group = grp_ld_bcde_a;
                    8'h0a, 8'h1a:               dec.group = grp_ld_a_bcde;
                    8'h22:                      dec.group = grp_ld_nn_hl;
                    8'h32:                      dec.group = grp_ld_nn_a;
                    8'h3a:                      dec.group = grp_ld_a_nn;
                    default:                    dec.group = grp_nop;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                           clk,
    input  wire                           reset,
    input  z80_pkg::reg_sel_e             rd_sel1,
    input  z80_pkg::reg_sel_e             rd_sel2,
    output logic [z80_pkg::word_w-1:0]    rd_data1,
    output logic [z80_pkg::word_w-1:0]    rd_data2,
    input  z80_pkg::reg_wr_t              wr
);
    import z80_pkg::*;

    logic [data_w-1:0] b;
    logic [data_w-1:0] c;
    logic [data_w-1:0] d;
    logic [data_w-1:0] e;
    logic [data_w-1:0] h;
    logic [data_w-1:0] l;
    logic [data_w-1:0] a;
    logic [word_w-1:0] sp;

    // 8-bit registers come back zero-extended
    function automatic logic [word_w-1:0] read_sel(input reg_sel_e sel);
        case (sel)
            reg_b:   read_sel = word_w'(b);
            reg_c:   read_sel = word_w'(c);
            reg_d:   read_sel = word_w'(d);
            reg_e:   read_sel = word_w'(e);
            reg_h:   read_sel = word_w'(h);
            reg_l:   read_sel = word_w'(l);
            reg_a:   read_sel = word_w'(a);
            reg_bc:  read_sel = {b, c};
            reg_de:  read_sel = {d, e};
            reg_hl:  read_sel = {h, l};
            reg_sp:  read_sel = sp;
            default: read_sel = '0;
        endcase
    endfunction

    always_comb begin
        rd_data1 = read_sel(rd_sel1);
        rd_data2 = read_sel(rd_sel2);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            b  <= '0;
            c  <= '0;
            d  <= '0;
            e  <= '0;
            h  <= '0;
            l  <= '0;
            a  <= '0;
            sp <= '0;
        end else if (wr.en) begin
            case (wr.dest)
                reg_b:   b <= wr.data[data_w-1:0];
                reg_c:   c <= wr.data[data_w-1:0];
                reg_d:   d <= wr.data[data_w-1:0];
                reg_e:   e <= wr.data[data_w-1:0];
                reg_h:   h <= wr.data[data_w-1:0];
                reg_l:   l <= wr.data[data_w-1:0];
                reg_a:   a <= wr.data[data_w-1:0];
                reg_bc:  {b, c} <= wr.data;  // high byte to B
                reg_de:  {d, e} <= wr.data;
                reg_hl:  {h, l} <= wr.data;
                reg_sp:  sp <= wr.data;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/z80_pkg.sv ====
`default_nettype none

package z80_pkg;

    localparam int addr_w = 16;
    localparam int data_w = 8;
    localparam int word_w = 16;

    // 0..7 follow the r field, pairs are dd + 8
    typedef enum logic [3:0] {
        reg_b  = 4'd0,
        reg_c  = 4'd1,
        reg_d  = 4'd2,
        reg_e  = 4'd3,
        reg_h  = 4'd4,
        reg_l  = 4'd5,
        reg_a  = 4'd7,
        reg_bc = 4'd8,
        reg_de = 4'd9,
        reg_hl = 4'd10,
        reg_sp = 4'd11
    } reg_sel_e;

    typedef enum logic [3:0] {
        grp_nop,
        grp_ld_r_r,
        grp_ld_r_n,
        grp_ld_hl_r,
        grp_ld_hl_n,
        grp_ld_a_bcde,
        grp_ld_bcde_a,
        grp_ld_a_nn,
        grp_ld_nn_a,
        grp_ld_dd_nn,
        grp_ld_nn_hl
    } insn_group_e;

    // cycle index inside one instruction
    typedef enum logic [2:0] {
        st_0,
        st_1,
        st_2,
        st_3,
        st_4
    } seq_state_e;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              read;
        logic              write;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              en;
        reg_sel_e          dest;
        logic [word_w-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        insn_group_e group;
        reg_sel_e    dst;   // bits 5:3
        reg_sel_e    src;   // bits 2:0
        reg_sel_e    pair;  // bits 5:4
    } decode_t;

endpackage

`default_nettype wire

// ==== src/z80_seq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module z80_seq_top (
    input  wire                           clk,
    input  wire                           reset,
    input  wire  [z80_pkg::data_w-1:0]    mem_data,
    output z80_pkg::mem_req_t             mem_req,
    output logic                          done
);
    import z80_pkg::*;

    logic [data_w-1:0] opcode;
    decode_t           dec;
    reg_sel_e          rd_sel1;
    reg_sel_e          rd_sel2;
    logic [word_w-1:0] rd_data1;
    logic [word_w-1:0] rd_data2;
    reg_wr_t           wr;

    load_sequencer load_sequencer_i (
        .clk      (clk),
        .reset    (reset),
        .mem_data (mem_data),
        .opcode   (opcode),
        .dec      (dec),
        .rd_sel1  (rd_sel1),
        .rd_sel2  (rd_sel2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr       (wr),
        .mem_req  (mem_req),
        .done     (done)
    );

    opcode_decoder opcode_decoder_i (
        .opcode (opcode),
        .dec    (dec)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .rd_sel1  (rd_sel1),
        .rd_sel2  (rd_sel2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr       (wr)
    );

endmodule

`default_nettype wire

// ==== test/tb_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_memory (
    input  wire                           clk,
    input  z80_pkg::mem_req_t             req,
    output logic [z80_pkg::data_w-1:0]    rdata
);
    import z80_pkg::*;

    logic [data_w-1:0] mem [0:(1 << addr_w)-1];

    // no read latency, data follows the address in the same cycle
    assign rdata = req.read ? mem[req.addr] : '0;

    always @(posedge clk) begin
        if (req.write)
            mem[req.addr] = req.wdata;
    end

    task automatic clear();
        for (int i = 0; i < (1 << addr_w); i++)
            mem[addr_w'(i)] = '0;  // zero bytes decode as nops
    endtask

    task automatic preload(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
        mem[a] = d;
    endtask

    function automatic logic [data_w-1:0] peek(input logic [addr_w-1:0] a);
        return mem[a];
    endfunction

endmodule

`default_nettype wire

// ==== test/z80_seq_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module z80_seq_sva (
    input wire               clk,
    input wire               reset,
    input z80_pkg::mem_req_t mem_req,
    input wire               done
);

    // a memory cycle is a read, a write or idle
    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.read && mem_req.write))
        else $error("read and write requested in the same cycle");

    // back to back writes only when the address moves on, as for H after L
    write_one_cycle: assert property (@(posedge clk) disable iff (reset)
        mem_req.write |=> !mem_req.write || (mem_req.addr != $past(mem_req.addr)))
        else $error("write held on one address for more than one cycle");

    done_with_fetch: assert property (@(posedge clk) disable iff (reset)
        done |-> mem_req.read)
        else $error("done raised without an opcode fetch");

endmodule

bind load_sequencer z80_seq_sva z80_seq_sva_i (
    .clk     (clk),
    .reset   (reset),
    .mem_req (mem_req),
    .done    (done)
);

`default_nettype wire

// ==== test/z80_seq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module z80_seq_tb;
    import z80_pkg::*;

    localparam int clk_period     = 100;
    localparam int reset_cycles   = 16;
    localparam int num_tests      = 5;
    localparam int max_run_cycles = 24;  // longest program is 16 cycles
    localparam int watchdog_ns    = num_tests * (reset_cycles + max_run_cycles) * clk_period;

    logic              clk;
    logic              reset;
    logic [data_w-1:0] mem_data;
    mem_req_t          mem_req;
    logic              done;
    logic [data_w-1:0] program_q[$];
    int                write_cycle_q[$];  // write cycles of the last instruction

    z80_seq_top z80_seq_top_i (
        .clk      (clk),
        .reset    (reset),
        .mem_data (mem_data),
        .mem_req  (mem_req),
        .done     (done)
    );

    tb_memory mem_i (
        .clk   (clk),
        .req   (mem_req),
        .rdata (mem_data)
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(watchdog_ns);
        $display("timeout: no result after %0d ns, the DUT seems stuck", watchdog_ns);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic start_reset();
        @(negedge clk);
        reset = 1'b1;
        mem_i.clear();
    endtask

    task automatic end_reset();
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic load_program();
        foreach (program_q[i])
            mem_i.preload(addr_w'(i), program_q[i]);
    endtask

    // called on the falling edge of an instruction's first cycle
    task automatic run_insn(input int cycles, input int len, input int writes);
        logic [addr_w-1:0] pc;
        int                n;
        int                w;
        compare(32'(done), 1, "done at instruction start");
        compare(32'(mem_req.read), 1, "opcode fetch read");
        pc = mem_req.addr;
        n  = 0;
        w  = 0;
        write_cycle_q.delete();
        do begin
            compare(32'(mem_req.read & mem_req.write), 0, "read and write high together");
            if (mem_req.write) begin
                w++;
                write_cycle_q.push_back(n);
            end
            @(negedge clk);
            n++;
        end while (!done);
        compare(n, cycles, "instruction cycle count");
        compare(w, writes, "write cycles in instruction");
        compare(32'(mem_req.addr), 32'(pc + addr_w'(len)), "next pc");
    endtask

    task automatic reset_state();
        start_reset();
        end_reset();
        compare(32'(done), 1, "done after reset");
        compare(32'(mem_req.read), 1, "read after reset");
        compare(32'(mem_req.write), 0, "write after reset");
        compare(32'(mem_req.addr), 0, "addr after reset");
        repeat (8) run_insn(1, 1, 0);  // memory of zeros
    endtask

    task automatic reg_load_store();
        logic [data_w-1:0] rv;
        logic [data_w-1:0] n2;
        rv = 8'($urandom_range(1, 255));
        n2 = rv ^ 8'($urandom_range(1, 255));  // never equal to rv
        start_reset();
        program_q = '{8'h26, 8'h40, 8'h2e, 8'h20, 8'h06, rv, 8'h48, 8'h71, 8'h36, n2};
        load_program();
        end_reset();
        run_insn(2, 2, 0);  // LD H,n
        run_insn(2, 2, 0);  // LD L,n
        run_insn(2, 2, 0);  // LD B,n
        run_insn(1, 1, 0);  // LD C,B
        run_insn(2, 1, 1);  // LD (HL),C
        compare(32'(mem_i.peek(16'h4020)), 32'(rv), "byte at HL after LD (HL),C");
        run_insn(3, 2, 1);  // LD (HL),n
        compare(32'(mem_i.peek(16'h4020)), 32'(n2), "byte at HL after LD (HL),n");
    endtask

    task automatic pair_addressing();
        logic [data_w-1:0] va;
        logic [data_w-1:0] vb;
        va = 8'($urandom_range(1, 255));
        do
            vb = 8'($urandom_range(1, 255));  // nonzero and unlike va
        while (vb == va);
        start_reset();
        mem_i.preload(16'h6044, vb);
        program_q = '{8'h11, 8'h23, 8'h51, 8'h3e, va, 8'h12,
                      8'h01, 8'h44, 8'h60, 8'h0a, 8'h32, 8'h88, 8'h70};
        load_program();
        end_reset();
        run_insn(3, 3, 0);  // LD DE,nn
        run_insn(2, 2, 0);  // LD A,n
        run_insn(2, 1, 1);  // LD (DE),A
        compare(32'(mem_i.peek(16'h5123)), 32'(va), "byte stored through DE");
        run_insn(3, 3, 0);  // LD BC,nn
        run_insn(2, 1, 0);  // LD A,(BC)
        run_insn(4, 3, 1);  // LD (nn),A
        compare(32'(mem_i.peek(16'h7088)), 32'(vb), "byte loaded through BC");
    endtask

    task automatic absolute_addressing();
        logic [data_w-1:0] vc;
        logic [word_w-1:0] hl_val;
        vc             = 8'($urandom_range(1, 255));
        hl_val[7:0]    = 8'($urandom_range(1, 255));
        do
            hl_val[15:8] = 8'($urandom_range(1, 255));  // H and L told apart
        while (hl_val[15:8] == hl_val[7:0]);
        start_reset();
        mem_i.preload(16'h4567, vc);
        program_q = '{8'h3a, 8'h67, 8'h45, 8'h32, 8'h00, 8'h46,
                      8'h21, hl_val[7:0], hl_val[15:8], 8'h22, 8'h00, 8'h47};
        load_program();
        end_reset();
        run_insn(4, 3, 0);  // LD A,(nn)
        run_insn(4, 3, 1);  // LD (nn),A
        compare(32'(mem_i.peek(16'h4600)), 32'(vc), "byte stored by LD (nn),A");
        run_insn(3, 3, 0);  // LD HL,nn
        run_insn(5, 3, 2);  // LD (nn),HL
        compare(32'(mem_i.peek(16'h4700)), 32'(hl_val[7:0]), "L at nn");
        compare(32'(mem_i.peek(16'h4701)), 32'(hl_val[15:8]), "H at nn+1");
        compare(write_cycle_q[1], write_cycle_q[0] + 1, "H written right after L");
    endtask

    task automatic unknown_opcodes();
        start_reset();
        program_q = '{8'h76, 8'hc3};
        load_program();
        end_reset();
        run_insn(1, 1, 0);  // halt slot
        run_insn(1, 1, 0);  // JP nn is not a load
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        void'($urandom(6));
        reset_state();
        reg_load_store();
        pair_addressing();
        absolute_addressing();
        unknown_opcodes();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
